//--- hdl/amba_pkg.sv
// Address is fixed at 12 bits and data at 32 bits and there are no IDs, bursts or user fields
package amba_pkg;

  // --------------------------------------------------
  // Widths
  // --------------------------------------------------
  localparam int ADDR_W = 12;
  localparam int DATA_W = 32;
  localparam int BYTE_W = 8;
  localparam int STRB_W = DATA_W / BYTE_W;
  localparam int PROT_W = 3;
  localparam int RESP_W = 2;

  // Address map
  // Bits 11..8 pick the bank, bits 4..2 the word, bits 7..5 must be zero
  localparam int BANK_SEL_LSB = 8;
  localparam int BANK_SEL_W = ADDR_W - BANK_SEL_LSB;
  localparam int NUM_WORDS = 8;
  localparam int CNT_WORD = 7;
  localparam int WORD_IDX_LSB = 2;
  localparam int WORD_IDX_W = $clog2(NUM_WORDS);

  // Index of the non-secure bit within prot
  localparam int PROT_NONSECURE = 1;

  // --------------------------------------------------
  // Vector types
  // --------------------------------------------------
  typedef logic [ADDR_W-1:0] addr_t;
  typedef logic [DATA_W-1:0] data_t;
  typedef logic [STRB_W-1:0] strb_t;
  typedef logic [PROT_W-1:0] prot_t;
  typedef logic [RESP_W-1:0] resp_t;
  typedef logic [BANK_SEL_W-1:0] bank_sel_t;
  typedef logic [WORD_IDX_W-1:0] word_idx_t;

  localparam resp_t RESP_OKAY = 2'b00;
  localparam resp_t RESP_SLVERR = 2'b10;

  // --------------------------------------------------
  // Channel structs
  // --------------------------------------------------
  typedef struct packed {addr_t addr; prot_t prot;} axil_aw_t;
  typedef struct packed {data_t data; strb_t strb;} axil_w_t;
  typedef struct packed {data_t data; resp_t resp;} axil_r_t;

  // One request shared by all completers, psel goes separately
  typedef struct packed {
    addr_t paddr;
    prot_t pprot;
    logic  pwrite;
    data_t pwdata;
    strb_t pstrb;
    logic  penable;
  } apb_req_t;

  typedef struct packed {
    data_t prdata;
    logic  pready;
    logic  pslverr;
  } apb_rsp_t;

endpackage

//--- hdl/rr_arbiter.sv
// Two requesters only and bit 1 is granted first after reset since the pointer starts at bit 0
`timescale 1ns/10ps

module rr_arbiter (
  input  logic       clk,
  input  logic       rst_n,
  input  logic [1:0] req,
  output logic [1:0] grant
);

  // Index of the requester granted most recently
  logic last_q;

  // --------------------------------------------------
  // Grant logic
  // --------------------------------------------------
  always_comb begin
    grant = 2'b00;
    if (req == 2'b11) begin
      // Tie goes to whoever did not win last time
      if (last_q) begin
        grant = 2'b01;
      end else begin
        grant = 2'b10;
      end
    end else begin
      // Single or no request passes straight through
      grant = req;
    end
  end

  // Pointer moves on every grant
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      // Pretend bit 0 won last so bit 1 wins the first tie
      last_q <= 1'b0;
    end else if (|grant) begin
      last_q <= grant[1];
    end
  end

endmodule

//--- hdl/axil2apb_bridge.sv
// One AXI4-Lite transfer at a time with no IDs or bursts, and AW and W must arrive together
`timescale 1ns/10ps

module axil2apb_bridge (
  input  logic               clk,
  input  logic               rst_n,
  // AXI4-Lite write address and data
  input  amba_pkg::axil_aw_t aw,
  input  logic               awvalid,
  output logic               awready,
  input  amba_pkg::axil_w_t  w,
  input  logic               wvalid,
  output logic               wready,
  // Write response
  output amba_pkg::resp_t    bresp,
  output logic               bvalid,
  input  logic               bready,
  // Read address and data
  input  amba_pkg::addr_t    araddr,
  input  amba_pkg::prot_t    arprot,
  input  logic               arvalid,
  output logic               arready,
  output amba_pkg::axil_r_t  r,
  output logic               rvalid,
  input  logic               rready,
  // APB requester side
  output amba_pkg::apb_req_t apb_req,
  output logic               psel,
  input  amba_pkg::apb_rsp_t apb_rsp
);
  import amba_pkg::*;

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_SETUP,
    ST_ACCESS,
    ST_RESP
  } state_t;

  state_t     state_q;
  state_t     state_d;
  logic [1:0] arb_req;
  logic [1:0] arb_grant;
  logic       wr_grant;
  logic       rd_grant;
  logic       any_grant;
  logic       apb_done;
  logic       resp_done;

  // Captured transfer
  addr_t      addr_q;
  prot_t      prot_q;
  data_t      wdata_q;
  strb_t      strb_q;
  logic       write_q;
  data_t      rdata_q;
  logic       err_q;

  // --------------------------------------------------
  // Read/write arbitration
  // --------------------------------------------------
  // Bit 1 is the write, bit 0 the read
  assign arb_req[1] = awvalid && wvalid && (state_q == ST_IDLE);
  assign arb_req[0] = arvalid && (state_q == ST_IDLE);

  rr_arbiter u_arb (
    .clk  (clk),
    .rst_n(rst_n),
    .req  (arb_req),
    .grant(arb_grant)
  );

  assign wr_grant = arb_grant[1];
  assign rd_grant = arb_grant[0];
  assign any_grant = wr_grant || rd_grant;

  // Completion events
  assign apb_done = (state_q == ST_ACCESS) && apb_rsp.pready;
  assign resp_done = write_q ? bready : rready;

  // --------------------------------------------------
  // State machine
  // --------------------------------------------------
  always_comb begin
    state_d = state_q;
    case (state_q)
      ST_IDLE: begin
        if (any_grant) begin
          state_d = ST_SETUP;
        end
      end
      ST_SETUP: begin
        state_d = ST_ACCESS;
      end
      ST_ACCESS: begin
        // Hold access phase until the completer is ready
        if (apb_rsp.pready) begin
          state_d = ST_RESP;
        end
      end
      ST_RESP: begin
        if (resp_done) begin
          state_d = ST_IDLE;
        end
      end
      default: begin
        state_d = ST_IDLE;
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state_q <= ST_IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  // Capture request on the grant
  always_ff @(posedge clk) begin
    if (any_grant) begin
      addr_q  <= wr_grant ? aw.addr : araddr;
      prot_q  <= wr_grant ? aw.prot : arprot;
      wdata_q <= w.data;
      // Reads carry no strobes on APB
      strb_q  <= wr_grant ? w.strb : '0;
      write_q <= wr_grant;
    end
  end

  // Capture completer answer at pready
  always_ff @(posedge clk) begin
    if (apb_done) begin
      rdata_q <= apb_rsp.prdata;
      err_q   <= apb_rsp.pslverr;
    end
  end

  // --------------------------------------------------
  // AXI4-Lite outputs
  // --------------------------------------------------
  assign awready = wr_grant;
  assign wready = wr_grant;
  assign arready = rd_grant;
  assign bvalid = (state_q == ST_RESP) && write_q;
  assign rvalid = (state_q == ST_RESP) && !write_q;
  assign bresp = err_q ? RESP_SLVERR : RESP_OKAY;
  assign r = '{data: rdata_q, resp: (err_q ? RESP_SLVERR : RESP_OKAY)};

  // APB outputs
  assign psel = (state_q == ST_SETUP) || (state_q == ST_ACCESS);
  assign apb_req = '{
    paddr:   addr_q,
    pprot:   prot_q,
    pwrite:  write_q,
    pwdata:  wdata_q,
    pstrb:   strb_q,
    penable: (state_q == ST_ACCESS)
  };

endmodule

//--- hdl/apb_decoder.sv
// Two banks only and bank 1 is secure, anything else gets an immediate SLVERR with zero data
`timescale 1ns/10ps

module apb_decoder (
  input  amba_pkg::apb_req_t apb_req,
  input  logic               psel,
  output amba_pkg::apb_rsp_t apb_rsp,
  output logic [1:0]         psel_bank,
  input  amba_pkg::apb_rsp_t rsp_bank0,
  input  amba_pkg::apb_rsp_t rsp_bank1
);
  import amba_pkg::*;

  bank_sel_t bank;
  logic      nonsecure;
  logic      hit0;
  logic      hit1;
  logic      access;

  // --------------------------------------------------
  // Address and protection decode
  // --------------------------------------------------
  assign bank = apb_req.paddr[BANK_SEL_LSB +: BANK_SEL_W];
  assign nonsecure = apb_req.pprot[PROT_NONSECURE];

  // Bank 0 takes any access
  assign hit0 = (bank == bank_sel_t'(0));
  // Bank 1 refuses non-secure traffic
  assign hit1 = (bank == bank_sel_t'(1)) && !nonsecure;

  assign access = psel && apb_req.penable;

  // Only the hit bank sees psel
  assign psel_bank[0] = psel && hit0;
  assign psel_bank[1] = psel && hit1;

  // --------------------------------------------------
  // Response mux
  // --------------------------------------------------
  always_comb begin
    if (hit0) begin
      apb_rsp = rsp_bank0;
    end else if (hit1) begin
      apb_rsp = rsp_bank1;
    end else begin
      // No bank selected so answer here without wait state
      apb_rsp.prdata  = '0;
      apb_rsp.pready  = access;
      apb_rsp.pslverr = access;
    end
  end

endmodule

//--- hdl/apb_reg_bank.sv
// Eight words with word 7 a read-only write count, and address bits 7 to 5 must be zero
`timescale 1ns/10ps

module apb_reg_bank (
  input  logic               clk,
  input  logic               rst_n,
  input  amba_pkg::apb_req_t apb_req,
  input  logic               psel,
  output amba_pkg::apb_rsp_t apb_rsp
);
  import amba_pkg::*;

  // Word CNT_WORD holds the write counter, the rest are plain registers
  data_t     regs [NUM_WORDS];
  data_t     rdata_q;
  logic      rd_err_q;
  logic      rd_done_q;
  word_idx_t idx;
  logic      pad_err;
  logic      access;
  logic      wr_err;
  logic      wr_ok;
  logic      rd_first;

  // --------------------------------------------------
  // Decode
  // --------------------------------------------------
  assign idx = apb_req.paddr[WORD_IDX_LSB +: WORD_IDX_W];
  // Gap between word index and bank field must be clear
  assign pad_err = |apb_req.paddr[BANK_SEL_LSB-1:WORD_IDX_LSB+WORD_IDX_W];

  assign access = psel && apb_req.penable;
  // Counter word is read-only
  assign wr_err = pad_err || (idx == word_idx_t'(CNT_WORD));
  assign wr_ok = access && apb_req.pwrite && !wr_err;
  // First access cycle of a read starts the wait state
  assign rd_first = access && !apb_req.pwrite && !rd_done_q;

  // --------------------------------------------------
  // Write path
  // --------------------------------------------------
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      for (int i = 0; i < NUM_WORDS; i++) begin
        regs[i] <= '0;
      end
    end else if (wr_ok) begin
      // Lane by lane under pstrb
      for (int b = 0; b < STRB_W; b++) begin
        if (apb_req.pstrb[b]) begin
          regs[idx][BYTE_W*b +: BYTE_W] <= apb_req.pwdata[BYTE_W*b +: BYTE_W];
        end
      end
      regs[CNT_WORD] <= regs[CNT_WORD] + 1'b1;
    end
  end

  // --------------------------------------------------
  // Read path with one wait state
  // --------------------------------------------------
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      rd_done_q <= 1'b0;
    end else begin
      rd_done_q <= rd_first;
    end
  end

  always_ff @(posedge clk) begin
    if (rd_first) begin
      // Bad offset reads back as zero
      rdata_q  <= pad_err ? '0 : regs[idx];
      rd_err_q <= pad_err;
    end
  end

  // Writes finish in the first access cycle
  always_comb begin
    apb_rsp.prdata  = rdata_q;
    apb_rsp.pready  = access && (apb_req.pwrite || rd_done_q);
    apb_rsp.pslverr = apb_rsp.pready && (apb_req.pwrite ? wr_err : rd_err_q);
  end

endmodule

//--- hdl/axil_apb_subsys.sv
// AXI4-Lite in front of two APB register banks and only one transfer is in flight at a time
`timescale 1ns/10ps

module axil_apb_subsys (
  input  logic               clk,
  input  logic               rst_n,
  input  amba_pkg::axil_aw_t aw,
  input  logic               awvalid,
  output logic               awready,
  input  amba_pkg::axil_w_t  w,
  input  logic               wvalid,
  output logic               wready,
  output amba_pkg::resp_t    bresp,
  output logic               bvalid,
  input  logic               bready,
  input  amba_pkg::addr_t    araddr,
  input  amba_pkg::prot_t    arprot,
  input  logic               arvalid,
  output logic               arready,
  output amba_pkg::axil_r_t  r,
  output logic               rvalid,
  input  logic               rready
);
  import amba_pkg::*;

  // --------------------------------------------------
  // APB fabric
  // --------------------------------------------------
  apb_req_t   apb_req;
  logic       psel;
  apb_rsp_t   apb_rsp;
  logic [1:0] psel_bank;
  apb_rsp_t   rsp_bank0;
  apb_rsp_t   rsp_bank1;

  axil2apb_bridge u_bridge (
    .clk    (clk),
    .rst_n  (rst_n),
    .aw     (aw),
    .awvalid(awvalid),
    .awready(awready),
    .w      (w),
    .wvalid (wvalid),
    .wready (wready),
    .bresp  (bresp),
    .bvalid (bvalid),
    .bready (bready),
    .araddr (araddr),
    .arprot (arprot),
    .arvalid(arvalid),
    .arready(arready),
    .r      (r),
    .rvalid (rvalid),
    .rready (rready),
    .apb_req(apb_req),
    .psel   (psel),
    .apb_rsp(apb_rsp)
  );

  apb_decoder u_dec (
    .apb_req  (apb_req),
    .psel     (psel),
    .apb_rsp  (apb_rsp),
    .psel_bank(psel_bank),
    .rsp_bank0(rsp_bank0),
    .rsp_bank1(rsp_bank1)
  );

  // Both banks see the same request
  apb_reg_bank bank0 (
    .clk    (clk),
    .rst_n  (rst_n),
    .apb_req(apb_req),
    .psel   (psel_bank[0]),
    .apb_rsp(rsp_bank0)
  );

  // Secure bank
  apb_reg_bank bank1 (
    .clk    (clk),
    .rst_n  (rst_n),
    .apb_req(apb_req),
    .psel   (psel_bank[1]),
    .apb_rsp(rsp_bank1)
  );

endmodule

//--- testbench/axil_apb_subsys_checker.sv
// Bridge protocol properties only, sampled on the rising clock and idle while rst_n is low
`timescale 1ns/10ps

module axil_apb_subsys_checker (
  input logic               clk,
  input logic               rst_n,
  input logic               awready,
  input logic               arready,
  input logic               bvalid,
  input logic               bready,
  input amba_pkg::resp_t    bresp,
  input logic               rvalid,
  input logic               rready,
  input amba_pkg::axil_r_t  r,
  input amba_pkg::apb_req_t apb_req,
  input logic               psel,
  input amba_pkg::apb_rsp_t apb_rsp
);
  import amba_pkg::*;

  // Number of failed assertions so far
  int assert_fails = 0;

  // --------------------------------------------------
  // APB phases
  // --------------------------------------------------
  // Setup cycle first, access on the next one
  a_setup_access: assert property (@(posedge clk) disable iff (!rst_n)
    $rose(psel) |-> !apb_req.penable ##1 apb_req.penable)
    else begin
      $error("APB psel rise not followed by penable");
      assert_fails++;
    end

  // Request frozen while the completer stalls
  a_req_stable: assert property (@(posedge clk) disable iff (!rst_n)
    (apb_req.penable && !apb_rsp.pready) |=> $stable(apb_req))
    else begin
      $error("APB request changed during wait state");
      assert_fails++;
    end

  // --------------------------------------------------
  // AXI4-Lite handshakes
  // --------------------------------------------------
  a_one_addr_ready: assert property (@(posedge clk) disable iff (!rst_n)
    !(awready && arready))
    else begin
      $error("awready and arready high together");
      assert_fails++;
    end

  a_one_resp_valid: assert property (@(posedge clk) disable iff (!rst_n)
    !(bvalid && rvalid))
    else begin
      $error("bvalid and rvalid high together");
      assert_fails++;
    end

  // Responses held until taken
  a_b_hold: assert property (@(posedge clk) disable iff (!rst_n)
    (bvalid && !bready) |=> (bvalid && $stable(bresp)))
    else begin
      $error("Write response dropped or changed before bready");
      assert_fails++;
    end

  a_r_hold: assert property (@(posedge clk) disable iff (!rst_n)
    (rvalid && !rready) |=> (rvalid && $stable(r)))
    else begin
      $error("Read response dropped or changed before rready");
      assert_fails++;
    end

endmodule

bind axil2apb_bridge axil_apb_subsys_checker u_checker (
  .clk    (clk),
  .rst_n  (rst_n),
  .awready(awready),
  .arready(arready),
  .bvalid (bvalid),
  .bready (bready),
  .bresp  (bresp),
  .rvalid (rvalid),
  .rready (rready),
  .r      (r),
  .apb_req(apb_req),
  .psel   (psel),
  .apb_rsp(apb_rsp)
);

//--- testbench/axil_apb_subsys_tb.sv
// Word-aligned accesses only, one transfer in flight, results checked at negedge against a model
`timescale 1ns/10ps

module axil_apb_subsys_tb;
  import amba_pkg::*;

  localparam int TIMEOUT = 50;
  localparam int ROUNDS = 10;
  localparam int STALLS = 4;
  localparam int ARB_PAIRS = 6;
  localparam prot_t SECURE = 3'b000;
  localparam prot_t NONSEC = 3'b010;

  logic     clk;
  logic     rst_n;
  axil_aw_t aw;
  logic     awvalid;
  logic     awready;
  axil_w_t  w;
  logic     wvalid;
  logic     wready;
  resp_t    bresp;
  logic     bvalid;
  logic     bready;
  addr_t    araddr;
  prot_t    arprot;
  logic     arvalid;
  logic     arready;
  axil_r_t  r;
  logic     rvalid;
  logic     rready;

  int       errors = 0;
  integer   seed = 49;
  // Model of both banks with the write count in word CNT_WORD
  data_t    model [2][NUM_WORDS];
  resp_t    exp_b_q [$];
  axil_r_t  exp_r_q [$];
  // 1 for a write acceptance, 0 for a read
  logic     accept_log [$];

  axil_apb_subsys dut0 (
    .clk    (clk),
    .rst_n  (rst_n),
    .aw     (aw),
    .awvalid(awvalid),
    .awready(awready),
    .w      (w),
    .wvalid (wvalid),
    .wready (wready),
    .bresp  (bresp),
    .bvalid (bvalid),
    .bready (bready),
    .araddr (araddr),
    .arprot (arprot),
    .arvalid(arvalid),
    .arready(arready),
    .r      (r),
    .rvalid (rvalid),
    .rready (rready)
  );

  initial begin
    clk = 1'b0;
    forever begin
      #4 clk = ~clk;
    end
  end

  // --------------------------------------------------
  // Compare and end-of-run helpers
  // --------------------------------------------------
  task automatic check_resp(input string name, input resp_t exp, input resp_t act);
    if (act !== exp) begin
      errors++;
      $display("Error at %0t: %s expected %0h, got %0h", $time, name, exp, act);
    end
  endtask

  task automatic check_data(input string name, input data_t exp, input data_t act);
    if (act !== exp) begin
      errors++;
      $display("Error at %0t: %s expected %08h, got %08h", $time, name, exp, act);
    end
  endtask

  task automatic check_bit(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      errors++;
      $display("Error at %0t: %s expected %0b, got %0b", $time, name, exp, act);
    end
  endtask

  task automatic end_of_test();
    errors += dut0.u_bridge.u_checker.assert_fails;
    $display("Run finished with %0d errors", errors);
    if (errors == 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  endtask

  task automatic timeout_fail(input string what);
    errors++;
    $display("Timeout at %0t: %s", $time, what);
    end_of_test();
  endtask

  // --------------------------------------------------
  // Reference model
  // --------------------------------------------------
  function automatic addr_t make_addr(input int bank, input int word, input int pad);
    return addr_t'((bank << BANK_SEL_LSB) | (pad << 5) | (word << 2));
  endfunction

  // Bits 11..8 bank, 7..5 must be zero, 4..2 word
  function automatic void ref_access(input logic is_write, input addr_t addr, input prot_t prot,
                                     input data_t wdata, input strb_t strb,
                                     output data_t rdata, output resp_t resp);
    int bank;
    int word;
    bank = int'(addr[11:BANK_SEL_LSB]);
    word = int'(addr[4:2]);
    rdata = '0;
    resp = RESP_OKAY;
    if (bank > 1 || (bank == 1 && prot[PROT_NONSECURE]) || addr[7:5] != 3'b000) begin
      resp = RESP_SLVERR;
    end else if (is_write) begin
      if (word == CNT_WORD) begin
        resp = RESP_SLVERR;
      end else begin
        for (int b = 0; b < 4; b++) begin
          if (strb[b]) begin
            model[bank][word][8*b +: 8] = wdata[8*b +: 8];
          end
        end
        model[bank][CNT_WORD] = model[bank][CNT_WORD] + 32'd1;
      end
    end else begin
      rdata = model[bank][word];
    end
  endfunction

  // Handshakes seen at negedge complete on the next rising edge
  initial begin : compare_proc
    data_t   exp_d;
    resp_t   exp_rsp;
    axil_r_t exp_rd;
    forever begin
      @(negedge clk);
      if (rst_n) begin
        if (awvalid && awready) begin
          ref_access(1'b1, aw.addr, aw.prot, w.data, w.strb, exp_d, exp_rsp);
          exp_b_q.push_back(exp_rsp);
          accept_log.push_back(1'b1);
        end
        if (arvalid && arready) begin
          ref_access(1'b0, araddr, arprot, '0, '0, exp_d, exp_rsp);
          exp_rd.data = exp_d;
          exp_rd.resp = exp_rsp;
          exp_r_q.push_back(exp_rd);
          accept_log.push_back(1'b0);
        end
        if (bvalid && bready) begin
          if (exp_b_q.size() == 0) begin
            errors++;
            $display("Write response at %0t without an accepted write", $time);
          end else begin
            check_resp("bresp", exp_b_q.pop_front(), bresp);
          end
        end
        if (rvalid && rready) begin
          if (exp_r_q.size() == 0) begin
            errors++;
            $display("Read response at %0t without an accepted read", $time);
          end else begin
            exp_rd = exp_r_q.pop_front();
            check_resp("r.resp", exp_rd.resp, r.resp);
            check_data("r.data", exp_rd.data, r.data);
          end
        end
      end
    end
  end

  // --------------------------------------------------
  // AXI4-Lite stimulus
  // --------------------------------------------------
  task automatic reset_dut();
    rst_n = 1'b0;
    aw = '0;
    awvalid = 1'b0;
    w = '0;
    wvalid = 1'b0;
    bready = 1'b1;
    araddr = '0;
    arprot = '0;
    arvalid = 1'b0;
    rready = 1'b1;
    for (int b = 0; b < 2; b++) begin
      for (int i = 0; i < NUM_WORDS; i++) begin
        model[b][i] = '0;
      end
    end
    exp_b_q.delete();
    exp_r_q.delete();
    accept_log.delete();
    repeat (2) @(posedge clk);
    #1;
    rst_n = 1'b1;
  endtask

  // Called 1 ns after a rising edge, returns 1 ns after one
  task automatic axil_write(input addr_t addr, input prot_t prot, input data_t data,
                            input strb_t strb);
    int cnt;
    aw = '{addr: addr, prot: prot};
    w = '{data: data, strb: strb};
    awvalid = 1'b1;
    wvalid = 1'b1;
    cnt = 0;
    do begin
      @(negedge clk);
      cnt++;
    end while (!(awready && wready) && cnt < TIMEOUT);
    if (!(awready && wready)) begin
      timeout_fail("write address and data were never accepted");
    end
    @(posedge clk);
    #1;
    awvalid = 1'b0;
    wvalid = 1'b0;
    cnt = 0;
    do begin
      @(negedge clk);
      cnt++;
    end while (!(bvalid && bready) && cnt < TIMEOUT);
    if (!(bvalid && bready)) begin
      timeout_fail("no write response handshake");
    end
    @(posedge clk);
    #1;
  endtask

  task automatic axil_read(input addr_t addr, input prot_t prot);
    int cnt;
    araddr = addr;
    arprot = prot;
    arvalid = 1'b1;
    cnt = 0;
    do begin
      @(negedge clk);
      cnt++;
    end while (!arready && cnt < TIMEOUT);
    if (!arready) begin
      timeout_fail("read address was never accepted");
    end
    @(posedge clk);
    #1;
    arvalid = 1'b0;
    cnt = 0;
    do begin
      @(negedge clk);
      cnt++;
    end while (!(rvalid && rready) && cnt < TIMEOUT);
    if (!(rvalid && rready)) begin
      timeout_fail("no read response handshake");
    end
    @(posedge clk);
    #1;
  endtask

  task automatic write_read(input addr_t addr, input prot_t prot, input data_t data,
                            input strb_t strb);
    axil_write(addr, prot, data, strb);
    axil_read(addr, prot);
  endtask

  // Stalls the pending response and offers the other direction meanwhile
  task automatic hold_response(input logic on_write, input int hold, input addr_t addr,
                               input data_t data);
    int    cnt;
    resp_t held_resp;
    data_t held_data;
    cnt = 0;
    do begin
      @(negedge clk);
      cnt++;
    end while (!(on_write ? bvalid : rvalid) && cnt < TIMEOUT);
    if (!(on_write ? bvalid : rvalid)) begin
      timeout_fail("stalled response never became valid");
    end
    held_resp = on_write ? bresp : r.resp;
    held_data = r.data;
    @(posedge clk);
    #1;
    if (on_write) begin
      araddr = addr;
      arprot = SECURE;
      arvalid = 1'b1;
    end else begin
      aw = '{addr: addr, prot: SECURE};
      w = '{data: data, strb: '1};
      awvalid = 1'b1;
      wvalid = 1'b1;
    end
    repeat (hold) begin
      @(negedge clk);
      check_bit("awready", 1'b0, awready);
      check_bit("wready", 1'b0, wready);
      check_bit("arready", 1'b0, arready);
      if (on_write) begin
        check_bit("bvalid", 1'b1, bvalid);
        check_resp("bresp", held_resp, bresp);
      end else begin
        check_bit("rvalid", 1'b1, rvalid);
        check_resp("r.resp", held_resp, r.resp);
        check_data("r.data", held_data, r.data);
      end
    end
    @(posedge clk);
    #1;
    bready = 1'b1;
    rready = 1'b1;
  endtask

  // --------------------------------------------------
  // Test sequence
  // --------------------------------------------------
  initial begin : main_proc
    addr_t a;
    data_t d;
    int    hold;
    reset_dut();

    $display("Strobed writes with read-back on both banks");
    for (int b = 0; b < 2; b++) begin
      for (int i = 0; i < ROUNDS; i++) begin
        a = make_addr(b, {$random(seed)} % CNT_WORD, 0);
        write_read(a, SECURE, data_t'($random(seed)), strb_t'($random(seed)));
      end
      axil_read(make_addr(b, CNT_WORD, 0), SECURE);
    end

    $display("Counter word");
    for (int b = 0; b < 2; b++) begin
      write_read(make_addr(b, CNT_WORD, 0), SECURE, 32'hDEAD_BEEF, '1);
      for (int i = 0; i < 3; i++) begin
        axil_write(make_addr(b, i, 0), SECURE, data_t'($random(seed)), '1);
      end
      axil_read(make_addr(b, CNT_WORD, 0), SECURE);
    end

    $display("Address map and secure bank errors");
    write_read(make_addr(2, 1, 0), SECURE, 32'h1234_5678, '1);
    write_read(make_addr(15, 6, 0), SECURE, 32'h8765_4321, '1);
    write_read(make_addr(0, 3, 1), SECURE, 32'hA5A5_A5A5, '1);
    write_read(make_addr(1, 2, 4), SECURE, 32'h5A5A_5A5A, '1);
    write_read(make_addr(1, 1, 0), NONSEC, 32'hCAFE_F00D, '1);
    axil_read(make_addr(1, CNT_WORD, 0), NONSEC);
    // Bank 0 accepts non-secure traffic
    write_read(make_addr(0, 2, 0), NONSEC, 32'h0BAD_CAFE, 4'b0101);
    // Secure read-back shows bank 1 untouched
    axil_read(make_addr(1, 1, 0), SECURE);
    axil_read(make_addr(1, CNT_WORD, 0), SECURE);
    axil_read(make_addr(0, CNT_WORD, 0), SECURE);

    $display("Response back-pressure");
    for (int k = 0; k < STALLS; k++) begin
      a = make_addr(k % 2, {$random(seed)} % CNT_WORD, 0);
      d = data_t'($random(seed));
      hold = 1 + ({$random(seed)} % 8);
      bready = 1'b0;
      fork
        axil_write(a, SECURE, d, '1);
        hold_response(1'b1, hold, a, '0);
      join
      axil_read(a, SECURE);
      d = data_t'($random(seed));
      hold = 1 + ({$random(seed)} % 8);
      rready = 1'b0;
      fork
        axil_read(a, SECURE);
        hold_response(1'b0, hold, a, d);
      join
      axil_write(a, SECURE, d, '1);
      axil_read(a, SECURE);
    end

    $display("Write and read arbitration");
    reset_dut();
    a = make_addr(1, 4, 0);
    fork
      begin
        for (int i = 0; i < ARB_PAIRS; i++) begin
          axil_write(a, SECURE, data_t'($random(seed)), '1);
        end
      end
      begin
        for (int i = 0; i < ARB_PAIRS; i++) begin
          axil_read(a, SECURE);
        end
      end
    join
    if (accept_log.size() != 2 * ARB_PAIRS) begin
      errors++;
      $display("Expected %0d acceptances in arbitration, saw %0d", 2 * ARB_PAIRS,
               accept_log.size());
    end else begin
      // Write wins the first tie, then each tie flips
      for (int i = 0; i < 2 * ARB_PAIRS; i++) begin
        check_bit($sformatf("accept_order[%0d]", i), (i % 2) == 0, accept_log[i]);
      end
    end

    if (exp_b_q.size() != 0 || exp_r_q.size() != 0) begin
      errors++;
      $display("Accepted transfers left without a response at the end");
    end
    end_of_test();
  end

endmodule

//--- build.f
hdl/amba_pkg.sv
hdl/rr_arbiter.sv
hdl/axil2apb_bridge.sv
hdl/apb_decoder.sv
hdl/apb_reg_bank.sv
hdl/axil_apb_subsys.sv
testbench/axil_apb_subsys_checker.sv
testbench/axil_apb_subsys_tb.sv

//--- Makefile
# Verilator build and run of the AXI4-Lite to APB register subsystem
# Any variable below can be overridden on the command line

VERILATOR ?= verilator
TOP       ?= axil_apb_subsys_tb
FILELIST  ?= build.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal
SIM_ARGS  ?= +verilator+error+limit+100
PASS_TEXT ?= ALL TESTS PASSED

SIM_BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, fail unless it passes"
	@echo "  clean  remove the Verilator output directory"
	@echo "  help   show this list"
	@echo "Variables: VERILATOR TOP FILELIST OBJ_DIR VFLAGS SIM_ARGS PASS_TEXT"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$($(SIM_BIN) $(SIM_ARGS))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF "$(PASS_TEXT)"

clean:
	rm -rf $(OBJ_DIR)
